// ==== files.f ====
verilog/isp_axi_pkg.sv
verilog/isp_focus_pkg.sv
verilog/axi_burst_reader.sv
verilog/center_gather.sv
verilog/contrast_engine.sv
verilog/isp_top.sv
tests/axi_dram_model.sv
tests/isp_asserts.sv
tests/tb_isp.sv

// ==== run.sh ====
#!/bin/sh
# build and run the auto-focus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f files.f --top-module tb_isp

# exit status is nonzero on any $fatal
./obj_dir/Vtb_isp

// ==== tests/tb_isp.sv ====
module tb_isp
    import isp_axi_pkg::*;
    import isp_focus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    pic_no_t    in_pic_no;
    logic [3:0] arid;
    logic [2:0] arsize;
    logic [1:0] arburst;
    axi_addr_t  araddr;
    logic [7:0] arlen;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic       rvalid;
    logic       rready;
    logic       out_valid;
    logic [7:0] out_data;

    int         seed;
    string      test_name;
    logic [7:0] exp_focus [32];
    axi_addr_t  exp_addr [64];
    int         n_req;
    int         n_addr;
    int         n_results;
    int         n_ar;
    int         n_bursts;
    logic [7:0] focus_head;
    axi_addr_t  addr_head;

    isp_top UUT (.*);

    axi_dram_model dram (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_results <= 0;
            n_ar      <= 0;
            n_bursts  <= 0;
        end else begin
            if (out_valid) begin
                n_results <= n_results + 1;
            end
            if (arvalid && arready) begin
                n_ar <= n_ar + 1;
            end
            if (rvalid && rready && rlast) begin
                n_bursts <= n_bursts + 1;
            end
        end
    end

    assign focus_head = exp_focus[n_results];
    assign addr_head  = exp_addr[n_ar];

    // ==============================
    // result and address checks
    // ==============================
    result_check: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_data == focus_head)
        else begin
            $display("Mismatch test %s: out_data expected %0d, actual %0d",
                     test_name, $sampled(focus_head), $sampled(out_data));
            $display("*** FAILED ***");
            $fatal(1, "result mismatch");
        end

    addr_check: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |-> araddr == addr_head)
        else begin
            $display("Mismatch test %s: araddr expected %h, actual %h",
                     test_name, $sampled(addr_head), $sampled(araddr));
            $display("*** FAILED ***");
            $fatal(1, "address mismatch");
        end

    // ==============================
    // reference model
    // ==============================
    function automatic int gray_at(input int pic, input int r, input int c);
        int off;
        int red;
        int green;
        int blue;
        off   = pic * PIC_BYTES + (WIN_ORIGIN + r) * IMG_W + WIN_ORIGIN + c;
        red   = int'(dram.mem[off]);
        green = int'(dram.mem[off + PLANE_BYTES]);
        blue  = int'(dram.mem[off + 2 * PLANE_BYTES]);
        return (red + 2 * green + blue) / 4;
    endfunction

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // pairs that start and end inside the centered k x k square
    function automatic int region_sum(input int pic, input int k);
        int lo;
        int hi;
        int sum;
        lo  = (WIN - k) / 2;
        hi  = lo + k - 1;
        sum = 0;
        for (int r = lo; r <= hi; r++) begin
            for (int c = lo; c <= hi; c++) begin
                if (c < hi) begin
                    sum += abs_diff(gray_at(pic, r, c), gray_at(pic, r, c + 1));
                end
                if (r < hi) begin
                    sum += abs_diff(gray_at(pic, r, c), gray_at(pic, r + 1, c));
                end
            end
        end
        return sum;
    endfunction

    function automatic logic [7:0] expected_focus(input int pic);
        int d2;
        int d4;
        int d6;
        d2 = region_sum(pic, 2) / 4;
        d4 = region_sum(pic, 4) / 16;
        d6 = region_sum(pic, 6) / 36;
        if (d2 >= d4 && d2 >= d6) begin
            return 8'd0;
        end else if (d4 >= d6) begin
            return 8'd1;
        end
        return 8'd2;
    endfunction

    // mode 1 center 2x2, 2 ring of the 4x4, 3 outer ring, else flat
    function automatic logic is_bright(input int mode, input int r, input int c);
        logic odd;
        logic ring4;
        odd   = ((r + c) % 2) == 1;
        ring4 = r >= 1 && r <= 4 && c >= 1 && c <= 4
             && !(r >= 2 && r <= 3 && c >= 2 && c <= 3);
        case (mode)
            1: return (r == 2 && c == 2) || (r == 3 && c == 3);
            2: return ring4 && odd;
            3: return (r == 0 || r == 5 || c == 0 || c == 5) && odd;
            default: return 1'b0;
        endcase
    endfunction

    task automatic paint_picture(input int pic, input int mode);
        int off;
        for (int i = 0; i < PIC_BYTES; i++) begin
            dram.mem[pic * PIC_BYTES + i] = 8'd100;
        end
        for (int r = 0; r < WIN; r++) begin
            for (int c = 0; c < WIN; c++) begin
                off = pic * PIC_BYTES + (WIN_ORIGIN + r) * IMG_W + WIN_ORIGIN + c;
                if (is_bright(mode, r, c)) begin
                    for (int p = 0; p < NUM_PLANES; p++) begin
                        dram.mem[off + p * PLANE_BYTES] = 8'd200;
                    end
                end
            end
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    task automatic issue_request(input int pic);
        exp_focus[n_req] = expected_focus(pic);
        n_req++;
        for (int p = 0; p < NUM_PLANES; p++) begin
            exp_addr[n_addr] = axi_addr_t'(DRAM_PIC_BASE + pic * PIC_BYTES
                                           + p * PLANE_BYTES + WIN_ORIGIN * IMG_W);
            n_addr++;
        end
        in_valid  = 1'b1;
        in_pic_no = pic_no_t'(pic);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (n_results < target) begin
            if (cycles == limit) begin
                $display("timeout in test %s: result %0d never came", test_name, target);
                $display("*** FAILED ***");
                $fatal(1, "timeout");
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic wait_bursts(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (n_bursts < target) begin
            if (cycles == limit) begin
                $display("timeout in test %s: read burst %0d never ended", test_name, target);
                $display("*** FAILED ***");
                $fatal(1, "timeout");
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic run_single(input string name, input int pic);
        test_name = name;
        issue_request(pic);
        wait_results(n_req, 2000);
    endtask

    initial begin
        int target;
        seed      = 16471;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pic_no = '0;
        n_req     = 0;
        n_addr    = 0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < 6; i++) begin
            run_single("random", $random(seed) & 15);
        end

        paint_picture(12, 1);
        paint_picture(13, 2);
        paint_picture(14, 3);
        paint_picture(15, 0);
        run_single("center_2x2", 12);
        run_single("ring_4x4", 13);
        run_single("outer_ring", 14);
        run_single("flat", 15);

        // second picture starts while the engine still works on the first
        test_name = "overlap";
        target    = n_bursts + NUM_PLANES;
        issue_request(13);
        wait_bursts(target, 2000);
        issue_request(14);
        wait_results(n_req, 2000);

        if (UUT.u_asserts.n_fail == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("protocol assertions failed %0d times", UUT.u_asserts.n_fail);
            $display("*** FAILED ***");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

// ==== tests/isp_asserts.sv ====
module isp_asserts
    import isp_axi_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       arvalid,
    input logic       arready,
    input axi_addr_t  araddr,
    input logic [7:0] arlen,
    input logic [3:0] arid,
    input logic [2:0] arsize,
    input logic [1:0] arburst,
    input logic       rready,
    input logic       out_valid,
    input logic [7:0] out_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int n_fail = 0;

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !arvalid && !rready && !out_valid)
        else begin
            n_fail++;
            $error("arvalid, rready or out_valid high during reset");
        end

    idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == 8'd0)
        else begin
            n_fail++;
            $error("out_data not zero while out_valid is low");
        end

    // address phase held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            n_fail++;
            $error("arvalid dropped or araddr changed before arready");
        end

    // twelve 16-byte beats, incrementing, id 0
    ar_attrs: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arlen == 8'd11 && arid == 4'd0
                 && arsize == 3'd4 && arburst == 2'd1)
        else begin
            n_fail++;
            $error("wrong arlen, arid, arsize or arburst on a read request");
        end

    out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            n_fail++;
            $error("out_valid high for more than one cycle");
        end

endmodule

bind isp_top isp_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .arlen     (arlen),
    .arid      (arid),
    .arsize    (arsize),
    .arburst   (arburst),
    .rready    (rready),
    .out_valid (out_valid),
    .out_data  (out_data)
);

// ==== tests/axi_dram_model.sv ====
module axi_dram_model
    import isp_axi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       arvalid,
    input  axi_addr_t  araddr,
    input  logic [7:0] arlen,
    output logic       arready,

    output axi_data_t  rdata,
    output logic [1:0] rresp,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_BYTES = 16 * PIC_BYTES;

    // byte 0 sits at DRAM_PIC_BASE
    logic [7:0] mem [MEM_BYTES];
    int         seed;
    logic       active_q;
    int         base_q;
    logic [7:0] len_q;
    logic [7:0] beat_q;

    initial begin
        seed = 16471;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'($random(seed));
        end
    end

    assign rresp = 2'b00;
    assign rlast = rvalid && beat_q == len_q;

    always_comb begin
        for (int b = 0; b < BEAT_BYTES; b++) begin
            rdata[8 * b +: 8] = mem[base_q + BEAT_BYTES * int'(beat_q) + b];
        end
    end

    // ==============================
    // one burst at a time, random stalls
    // ==============================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            active_q <= 1'b0;
            rvalid   <= 1'b0;
            base_q   <= 0;
            len_q    <= 8'd0;
            beat_q   <= 8'd0;
        end else begin
            arready <= 1'b0;
            if (!active_q) begin
                if (arvalid && arready) begin
                    active_q <= 1'b1;
                    base_q   <= int'(araddr) - DRAM_PIC_BASE;
                    len_q    <= arlen;
                    beat_q   <= 8'd0;
                end else if (arvalid && ($random(seed) & 3) == 0) begin
                    arready <= 1'b1;
                end
            end else if (rvalid && rready) begin
                if (rlast) begin
                    active_q <= 1'b0;
                    rvalid   <= 1'b0;
                end else begin
                    beat_q <= beat_q + 8'd1;
                    rvalid <= ($random(seed) & 3) != 0;
                end
            end else if (!rvalid) begin
                rvalid <= ($random(seed) & 3) != 0;
            end
        end
    end

endmodule

// ==== verilog/isp_top.sv ====
module isp_top
    import isp_axi_pkg::*;
    import isp_focus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       in_valid,
    input  pic_no_t    in_pic_no,

    // AXI read address
    output logic [3:0] arid,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output axi_addr_t  araddr,
    output logic [7:0] arlen,
    output logic       arvalid,
    input  logic       arready,

    // AXI read data
    input  axi_data_t  rdata,
    input  logic [1:0] rresp,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready,

    output logic       out_valid,
    output logic [7:0] out_data
);

    logic         beat_valid;
    logic         beat_ready;
    axi_data_t    beat_data;
    logic [1:0]   beat_plane;
    logic [3:0]   beat_idx;

    logic         win_valid;
    logic         win_ready;
    gray_window_t win_gray;

    assign arid    = AXI_ID;
    assign arsize  = AXI_SIZE_BEAT;
    assign arburst = AXI_BURST_INCR;

    // rresp and rlast unused, the reader counts beats itself
    axi_burst_reader u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_pic_no  (in_pic_no),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_plane (beat_plane),
        .beat_idx   (beat_idx),
        .beat_ready (beat_ready)
    );

    center_gather u_gather (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_plane (beat_plane),
        .beat_idx   (beat_idx),
        .beat_ready (beat_ready),
        .win_valid  (win_valid),
        .win_gray   (win_gray),
        .win_ready  (win_ready)
    );

    contrast_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win_gray  (win_gray),
        .win_ready (win_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verilog/contrast_engine.sv ====
module contrast_engine
    import isp_focus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         win_valid,
    input  gray_window_t win_gray,
    output logic         win_ready,

    output logic         out_valid,
    output logic [7:0]   out_data
);

    gray_window_t win_q;
    logic         busy_q;
    logic [5:0]   step_q;
    logic [2:0]   row_q;
    logic [2:0]   col_q;
    logic         vert_q;

    logic         win_fire;
    logic         pair_phase;
    logic         norm_phase;
    logic         cmp_phase;
    logic         out_phase;

    logic [5:0]   idx_a;
    logic [5:0]   idx_b;
    gray_t        pix_a;
    gray_t        pix_b;
    gray_t        diff;
    logic         in_s4;
    logic         in_s2;

    contrast_t    s2_q;
    contrast_t    s4_q;
    contrast_t    s6_q;
    contrast_t    d2_q;
    contrast_t    d4_q;
    contrast_t    d6_q;
    focus_sel_t   sel_q;

    // both pixels of the pair inside the centered k x k region
    function automatic logic in_region(input int k, input int r1, input int c1,
                                       input int r2, input int c2);
        int lo;
        int hi;
        lo = (WIN - k) / 2;
        hi = (WIN + k) / 2 - 1;
        return r1 >= lo && c1 >= lo && r2 <= hi && c2 <= hi;
    endfunction

    assign win_ready  = !busy_q;
    assign win_fire   = win_valid && win_ready;
    // 30 horizontal then 30 vertical pairs
    assign pair_phase = busy_q && step_q < 6'(2 * WIN * (WIN - 1));
    assign norm_phase = busy_q && step_q == 6'(2 * WIN * (WIN - 1));
    assign cmp_phase  = busy_q && step_q == 6'(2 * WIN * (WIN - 1) + 1);
    assign out_phase  = busy_q && step_q == 6'(2 * WIN * (WIN - 1) + 2);

    // ==============================
    // current pair
    // ==============================
    assign idx_a = 6'(row_q * WIN + col_q);
    assign idx_b = vert_q ? idx_a + 6'(WIN) : idx_a + 6'd1;
    assign pix_a = win_q[idx_a];
    assign pix_b = win_q[idx_b];
    assign diff  = (pix_a > pix_b) ? pix_a - pix_b : pix_b - pix_a;

    assign in_s4 = in_region(4, row_q, col_q, row_q + vert_q, col_q + !vert_q);
    assign in_s2 = in_region(2, row_q, col_q, row_q + vert_q, col_q + !vert_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            step_q    <= 6'd0;
            row_q     <= 3'd0;
            col_q     <= 3'd0;
            vert_q    <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= 8'd0;
        end else begin
            out_valid <= out_phase;
            out_data  <= out_phase ? 8'(sel_q) : 8'd0;
            if (win_fire) begin
                busy_q <= 1'b1;
                step_q <= 6'd0;
                row_q  <= 3'd0;
                col_q  <= 3'd0;
                vert_q <= 1'b0;
            end else if (busy_q) begin
                step_q <= step_q + 6'd1;
                if (out_phase) begin
                    busy_q <= 1'b0;
                end
                if (pair_phase && !vert_q) begin
                    if (col_q == 3'(WIN - 2)) begin
                        col_q <= 3'd0;
                        if (row_q == 3'(WIN - 1)) begin
                            row_q  <= 3'd0;
                            vert_q <= 1'b1;
                        end else begin
                            row_q <= row_q + 3'd1;
                        end
                    end else begin
                        col_q <= col_q + 3'd1;
                    end
                end else if (pair_phase) begin
                    if (col_q == 3'(WIN - 1)) begin
                        col_q <= 3'd0;
                        row_q <= row_q + 3'd1;
                    end else begin
                        col_q <= col_q + 3'd1;
                    end
                end
            end
        end
    end

    // ==============================
    // sums, normalize, compare
    // ==============================
    always_ff @(posedge clk) begin
        if (win_fire) begin
            win_q <= win_gray;
            s2_q  <= '0;
            s4_q  <= '0;
            s6_q  <= '0;
        end else if (pair_phase) begin
            s6_q <= s6_q + diff;
            if (in_s4) begin
                s4_q <= s4_q + diff;
            end
            if (in_s2) begin
                s2_q <= s2_q + diff;
            end
        end
        if (norm_phase) begin
            d2_q <= s2_q >> 2;
            d4_q <= s4_q >> 4;
            d6_q <= s6_q / contrast_t'(WIN * WIN);
        end
        // ties go to the smaller region
        if (cmp_phase) begin
            if (d2_q >= d4_q && d2_q >= d6_q) begin
                sel_q <= 2'd0;
            end else if (d4_q >= d6_q) begin
                sel_q <= 2'd1;
            end else begin
                sel_q <= 2'd2;
            end
        end
    end

endmodule

// ==== verilog/center_gather.sv ====
module center_gather
    import isp_axi_pkg::*;
    import isp_focus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         beat_valid,
    input  axi_data_t    beat_data,
    input  logic [1:0]   beat_plane,
    input  logic [3:0]   beat_idx,
    output logic         beat_ready,

    output logic         win_valid,
    output gray_window_t win_gray,
    input  logic         win_ready
);

    gray_sum_t  acc [WIN*WIN];
    gray_sum_t  addend [WIN/2];
    logic [5:0] base;
    logic       beat_fire;
    logic       win_fire;
    logic       last_beat;

    // byte of a beat that holds window column (half*3 + k)
    function automatic int byte_pos(input logic half, input int k);
        return (WIN_ORIGIN + (half ? WIN / 2 : 0) + k) % BEAT_BYTES;
    endfunction

    assign beat_ready = beat_valid && !win_valid;
    assign beat_fire  = beat_valid && beat_ready;
    assign win_fire   = win_valid && win_ready;
    assign last_beat  = beat_plane == 2'(NUM_PLANES - 1)
                     && beat_idx == 4'(BEATS_PER_PLANE - 1);

    // even beat is the left half of a window row, odd beat the right half
    assign base = 6'(beat_idx[3:1] * WIN + (beat_idx[0] ? WIN / 2 : 0));

    // green counts twice
    always_comb begin
        for (int k = 0; k < WIN / 2; k++) begin
            addend[k] = gray_sum_t'(beat_data[8 * byte_pos(beat_idx[0], k) +: 8])
                        << (beat_plane == 2'd1);
        end
    end

    // ==============================
    // accumulators
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WIN * WIN; i++) begin
                acc[i] <= '0;
            end
        end else if (win_fire) begin
            for (int i = 0; i < WIN * WIN; i++) begin
                acc[i] <= '0;
            end
        end else if (beat_fire) begin
            for (int k = 0; k < WIN / 2; k++) begin
                acc[base + k] <= acc[base + k] + addend[k];
            end
        end
    end

    // window ready after the last B beat, held until the engine takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else if (win_fire) begin
            win_valid <= 1'b0;
        end else if (beat_fire && last_beat) begin
            win_valid <= 1'b1;
        end
    end

    // divide by four
    always_comb begin
        for (int i = 0; i < WIN * WIN; i++) begin
            win_gray[i] = acc[i][9:2];
        end
    end

endmodule

// ==== verilog/axi_burst_reader.sv ====
module axi_burst_reader
    import isp_axi_pkg::*;
    import isp_focus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       in_valid,
    input  pic_no_t    in_pic_no,

    output axi_addr_t  araddr,
    output logic [7:0] arlen,
    output logic       arvalid,
    input  logic       arready,

    input  axi_data_t  rdata,
    input  logic       rvalid,
    output logic       rready,

    output logic       beat_valid,
    output axi_data_t  beat_data,
    output logic [1:0] beat_plane,
    output logic [3:0] beat_idx,
    input  logic       beat_ready
);

    logic       busy_q;
    pic_no_t    pic_q;
    logic [1:0] plane_q;
    logic [3:0] beat_cnt_q;
    logic       beat_fire;
    logic       last_beat;
    logic       last_plane;

    // ==============================
    // read address
    // ==============================
    // plane p of picture n, starting at window row 13
    assign araddr = axi_addr_t'(DRAM_PIC_BASE
                              + pic_q * PIC_BYTES
                              + plane_q * PLANE_BYTES
                              + WIN_ORIGIN * IMG_W);

    assign arlen = 8'(BEATS_PER_PLANE - 1);

    // ==============================
    // beat stream
    // ==============================
    // R channel flows straight through, the gather decides when to stall
    assign beat_valid = rvalid;
    assign beat_data  = rdata;
    assign rready     = beat_ready;
    assign beat_plane = plane_q;
    assign beat_idx   = beat_cnt_q;

    // beats only count once the address phase is over
    assign beat_fire  = busy_q && !arvalid && rvalid && beat_ready;
    assign last_beat  = beat_cnt_q == 4'(BEATS_PER_PLANE - 1);
    assign last_plane = plane_q == 2'(NUM_PLANES - 1);

    // picture number held for all three bursts
    always_ff @(posedge clk) begin
        if (!busy_q && in_valid) begin
            pic_q <= in_pic_no;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            arvalid    <= 1'b0;
            plane_q    <= 2'd0;
            beat_cnt_q <= 4'd0;
        end else begin
            if (!busy_q) begin
                // requests while busy are dropped
                if (in_valid) begin
                    busy_q     <= 1'b1;
                    arvalid    <= 1'b1;
                    plane_q    <= 2'd0;
                    beat_cnt_q <= 4'd0;
                end
            end else if (arvalid) begin
                if (arready) begin
                    arvalid <= 1'b0;
                end
            end else if (beat_fire) begin
                if (last_beat) begin
                    beat_cnt_q <= 4'd0;
                    if (last_plane) begin
                        busy_q <= 1'b0;
                    end else begin
                        // next plane, R then G then B
                        plane_q <= plane_q + 2'd1;
                        arvalid <= 1'b1;
                    end
                end else begin
                    beat_cnt_q <= beat_cnt_q + 4'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/isp_focus_pkg.sv ====
package isp_focus_pkg;

    // ==============================
    // window geometry
    // ==============================
    localparam int IMG_W = 32;
    localparam int WIN = 6;

    // first row and column of the centered window
    localparam int WIN_ORIGIN = 13;

    // two beats per window row, six rows
    localparam int BEATS_PER_PLANE = 12;
    localparam int NUM_PLANES = 3;

    // ==============================
    // pixel and result types
    // ==============================
    typedef logic [7:0] gray_t;

    // R + 2G + B, before the divide by four
    typedef logic [9:0] gray_sum_t;

    // pixel i is row i/6, column i%6
    typedef gray_t [WIN*WIN-1:0] gray_window_t;

    // sixty pairs of at most 255 fit easily
    typedef logic [15:0] contrast_t;

    // 0 for 2x2, 1 for 4x4, 2 for 6x6
    typedef logic [1:0] focus_sel_t;

endpackage

// ==== verilog/isp_axi_pkg.sv ====
package isp_axi_pkg;

    // ==============================
    // bus widths
    // ==============================
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 128;
    localparam int BEAT_BYTES = AXI_DATA_W / 8;

    // fixed AR attributes
    localparam logic [2:0] AXI_SIZE_BEAT  = 3'd4;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;
    localparam logic [3:0] AXI_ID         = 4'd0;

    // ==============================
    // picture layout in DRAM
    // ==============================
    // pictures back to back, each one R, G, B planes of 32x32 bytes
    localparam int DRAM_PIC_BASE = 'h1_0000;
    localparam int PIC_BYTES     = 3072;
    localparam int PLANE_BYTES   = 1024;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;

    // 16 pictures
    typedef logic [3:0] pic_no_t;

endpackage
